// ==== filelist.f ====
src/exu_pkg.sv
src/exu_issue.sv
src/exu_alu.sv
src/exu_divider.sv
src/exu_writeback.sv
src/exu_top.sv
tests/exu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module exu_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/Vexu_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "simulator exited with status $run_status"
   exit 1
fi

echo "simulation passed"
exit 0

// ==== src/exu_alu.sv ====
`default_nettype none

module exu_alu (
   input  wire  [exu_pkg::OP_W-1:0]   code_i,
   input  wire  [exu_pkg::XLEN-1:0]   a_i,
   input  wire  [exu_pkg::XLEN-1:0]   b_i,
   input  wire  [exu_pkg::XLEN-1:0]   imm_i,
   input  wire  [exu_pkg::XLEN-1:0]   pc_i,
   input  wire                        compressed_i,
   output logic [exu_pkg::XLEN-1:0]   result_o,
   output logic                       jmp_valid_o,
   output logic [exu_pkg::XLEN-1:0]   jmp_target_o
);
   import exu_pkg::*;

   logic        [SHAMT_W-1:0]  shamt;
   logic signed [2*XLEN-1:0]   prod_ss;
   logic signed [2*XLEN:0]     prod_su;
   logic        [2*XLEN-1:0]   prod_uu;
   logic        [XLEN-1:0]     link;
   logic        [XLEN-1:0]     jalr_sum;

   assign shamt = b_i[SHAMT_W-1:0];

   // full products, the high codes take the upper half
   assign prod_ss = $signed(a_i) * $signed(b_i);
   assign prod_su = $signed({a_i[XLEN-1], a_i}) * $signed({1'b0, b_i});
   assign prod_uu = a_i * b_i;

   assign link     = pc_i + (compressed_i ? XLEN'(2) : XLEN'(4));
   assign jalr_sum = a_i + imm_i;

   always_comb begin
      result_o = '0;
      case (code_i)
         OP_ADD: begin
            result_o = a_i + b_i;
         end
         OP_SUB: begin
            result_o = a_i - b_i;
         end
         OP_AND: begin
            result_o = a_i & b_i;
         end
         OP_OR: begin
            result_o = a_i | b_i;
         end
         OP_XOR: begin
            result_o = a_i ^ b_i;
         end
         OP_SLL: begin
            result_o = a_i << shamt;
         end
         OP_SRL: begin
            result_o = a_i >> shamt;
         end
         OP_SRA: begin
            result_o = $signed(a_i) >>> shamt;
         end
         OP_SLT: begin
            result_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
         end
         OP_SLTU: begin
            result_o = {{(XLEN-1){1'b0}}, a_i < b_i};
         end
         OP_MUL: begin
            result_o = prod_uu[XLEN-1:0];   // low half is sign agnostic
         end
         OP_MULH: begin
            result_o = prod_ss[2*XLEN-1:XLEN];
         end
         OP_MULHSU: begin
            result_o = prod_su[2*XLEN-1:XLEN];
         end
         OP_MULHU: begin
            result_o = prod_uu[2*XLEN-1:XLEN];
         end
         OP_LUI: begin
            result_o = imm_i;   // immediate arrives already shifted
         end
         OP_AUIPC: begin
            result_o = pc_i + imm_i;
         end
         OP_MEM: begin
            result_o = a_i + imm_i;
         end
         OP_JAL, OP_JALR: begin
            result_o = link;
         end
         default: begin
            result_o = '0;
         end
      endcase
   end

   assign jmp_valid_o = (code_i == OP_JAL) || (code_i == OP_JALR);

   always_comb begin
      if (code_i == OP_JALR) begin
         jmp_target_o = {jalr_sum[XLEN-1:1], 1'b0};
      end else begin
         jmp_target_o = pc_i + imm_i;
      end
   end

endmodule

`default_nettype wire

// ==== src/exu_divider.sv ====
`default_nettype none

module exu_divider (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        start_i,
   input  wire                        signed_i,
   input  wire                        rem_i,
   input  wire  [exu_pkg::XLEN-1:0]   dividend_i,
   input  wire  [exu_pkg::XLEN-1:0]   divisor_i,
   output logic                       busy_o,
   output logic                       done_o,
   output logic [exu_pkg::XLEN-1:0]   result_o
);
   import exu_pkg::*;

   logic                 run_q;
   logic                 fix_q;
   logic                 done_q;
   logic [DIV_CNT_W-1:0] cnt_q;
   logic [XLEN-1:0]      quo_q;
   logic [XLEN-1:0]      rem_q;
   logic [XLEN-1:0]      dsr_q;
   logic [XLEN-1:0]      dvd_q;      // original dividend for x/0
   logic                 quo_neg_q;
   logic                 rem_neg_q;
   logic                 zero_q;
   logic                 rem_sel_q;
   logic [XLEN-1:0]      result_q;
   logic [XLEN-1:0]      abs_dvd;
   logic [XLEN-1:0]      abs_dsr;
   logic [XLEN:0]        trial;
   logic [XLEN-1:0]      quo_fix;
   logic [XLEN-1:0]      rem_fix;

   assign abs_dvd = (signed_i && dividend_i[XLEN-1]) ? -dividend_i : dividend_i;
   assign abs_dsr = (signed_i && divisor_i[XLEN-1]) ? -divisor_i : divisor_i;

   assign trial = {rem_q, quo_q[XLEN-1]} - {1'b0, dsr_q};

   // most negative / -1 comes out of the magnitude path unchanged, rem 0
   assign quo_fix = zero_q ? '1 : (quo_neg_q ? -quo_q : quo_q);
   assign rem_fix = zero_q ? dvd_q : (rem_neg_q ? -rem_q : rem_q);

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         run_q  <= 1'b0;
         fix_q  <= 1'b0;
         done_q <= 1'b0;
         cnt_q  <= '0;
      end else begin
         done_q <= 1'b0;
         if (start_i) begin
            run_q <= 1'b1;
            cnt_q <= DIV_CNT_W'(DIV_CYCLES - 1);
         end else if (run_q) begin
            cnt_q <= cnt_q - 1'b1;
            if (cnt_q == '0) begin
               run_q <= 1'b0;
               fix_q <= 1'b1;
            end
         end else if (fix_q) begin
            fix_q  <= 1'b0;
            done_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         quo_q     <= abs_dvd;
         rem_q     <= '0;
         dsr_q     <= abs_dsr;
         dvd_q     <= dividend_i;
         quo_neg_q <= signed_i && (dividend_i[XLEN-1] ^ divisor_i[XLEN-1]);
         rem_neg_q <= signed_i && dividend_i[XLEN-1];
         zero_q    <= (divisor_i == '0);
         rem_sel_q <= rem_i;
      end else if (run_q) begin
         if (!trial[XLEN]) begin
            rem_q <= trial[XLEN-1:0];
            quo_q <= {quo_q[XLEN-2:0], 1'b1};
         end else begin
            rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};
            quo_q <= {quo_q[XLEN-2:0], 1'b0};
         end
      end else if (fix_q) begin
         result_q <= rem_sel_q ? rem_fix : quo_fix;
      end
   end

   assign busy_o   = run_q || fix_q;
   assign done_o   = done_q;
   assign result_o = result_q;

   a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
      done_o |=> !done_o);

endmodule

`default_nettype wire

// ==== src/exu_issue.sv ====
`default_nettype none

module exu_issue (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        op_valid_i,
   output logic                       op_ready_o,
   input  wire  [exu_pkg::OP_W-1:0]   op_code_i,
   input  wire                        imm_sel_i,
   input  wire  [exu_pkg::XLEN-1:0]   rs1_i,
   input  wire  [exu_pkg::XLEN-1:0]   rs2_i,
   input  wire  [exu_pkg::XLEN-1:0]   imm_i,
   input  wire  [exu_pkg::XLEN-1:0]   pc_i,
   input  wire                        compressed_i,
   input  wire                        wb_ready_i,
   input  wire                        div_busy_i,
   input  wire                        div_done_i,
   output logic                       iss_valid_o,
   output logic                       div_start_o,
   output logic                       alu_take_o,
   output logic [exu_pkg::OP_W-1:0]   iss_code_o,
   output logic [exu_pkg::XLEN-1:0]   iss_a_o,
   output logic [exu_pkg::XLEN-1:0]   iss_b_o,
   output logic [exu_pkg::XLEN-1:0]   iss_pc_o,
   output logic [exu_pkg::XLEN-1:0]   iss_imm_o,
   output logic                       iss_compressed_o
);
   import exu_pkg::*;

   logic [OP_W:0] ctrl;
   logic          valid_q;
   logic          started_q;   // divider already kicked for this entry
   logic          is_div;
   logic          accept;
   logic          release_entry;

   assign ctrl = {imm_sel_i, op_code_i};

   assign is_div = (iss_code_o == OP_DIV) || (iss_code_o == OP_DIVU) ||
                   (iss_code_o == OP_REM) || (iss_code_o == OP_REMU);

   assign alu_take_o    = !is_div;   // entry owned by the alu
   assign release_entry = valid_q && (alu_take_o ? wb_ready_i : div_done_i);
   assign op_ready_o    = !valid_q || release_entry;
   assign accept        = op_valid_i && op_ready_o;
   assign iss_valid_o   = valid_q;

   // writeback must be free now, so it is still free when the quotient lands
   assign div_start_o = valid_q && is_div && !started_q && !div_busy_i && wb_ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_q   <= 1'b0;
         started_q <= 1'b0;
      end else if (accept) begin
         valid_q   <= 1'b1;
         started_q <= 1'b0;
      end else if (release_entry) begin
         valid_q   <= 1'b0;
      end else if (div_start_o) begin
         started_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         iss_code_o       <= ctrl[OP_W-1:0];
         iss_a_o          <= rs1_i;
         iss_b_o          <= ctrl[USE_IMM_BIT] ? imm_i : rs2_i;
         iss_pc_o         <= pc_i;
         iss_imm_o        <= imm_i;
         iss_compressed_o <= compressed_i;
      end
   end

   // a busy divider always works on the entry that already started it
   a_busy_owned: assert property (@(posedge clk_i) disable iff (!rst_i)
      div_busy_i |-> valid_q && is_div && started_q);

   // a finished division always belongs to the entry still held here
   a_done_owned: assert property (@(posedge clk_i) disable iff (!rst_i)
      div_done_i |-> valid_q && is_div && started_q);

endmodule

`default_nettype wire

// ==== src/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

   localparam int XLEN = 32;
   localparam int OP_W = 5;
   localparam int SHAMT_W = $clog2(XLEN);

   // imm_sel sits one bit above the operation code
   localparam int USE_IMM_BIT = OP_W;

   localparam int DIV_CYCLES = 32;
   localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

   // arithmetic and logic
   localparam logic [OP_W-1:0] OP_ADD    = 5'd0;
   localparam logic [OP_W-1:0] OP_SUB    = 5'd1;
   localparam logic [OP_W-1:0] OP_AND    = 5'd2;
   localparam logic [OP_W-1:0] OP_OR     = 5'd3;
   localparam logic [OP_W-1:0] OP_XOR    = 5'd4;
   localparam logic [OP_W-1:0] OP_SLL    = 5'd5;
   localparam logic [OP_W-1:0] OP_SRL    = 5'd6;
   localparam logic [OP_W-1:0] OP_SRA    = 5'd7;
   localparam logic [OP_W-1:0] OP_SLT    = 5'd8;
   localparam logic [OP_W-1:0] OP_SLTU   = 5'd9;

   // M extension
   localparam logic [OP_W-1:0] OP_MUL    = 5'd10;
   localparam logic [OP_W-1:0] OP_MULH   = 5'd11;
   localparam logic [OP_W-1:0] OP_MULHSU = 5'd12;
   localparam logic [OP_W-1:0] OP_MULHU  = 5'd13;
   localparam logic [OP_W-1:0] OP_DIV    = 5'd14;
   localparam logic [OP_W-1:0] OP_DIVU   = 5'd15;
   localparam logic [OP_W-1:0] OP_REM    = 5'd16;
   localparam logic [OP_W-1:0] OP_REMU   = 5'd17;

   // upper immediate, address and jumps
   localparam logic [OP_W-1:0] OP_LUI    = 5'd18;
   localparam logic [OP_W-1:0] OP_AUIPC  = 5'd19;
   localparam logic [OP_W-1:0] OP_MEM    = 5'd20;
   localparam logic [OP_W-1:0] OP_JAL    = 5'd21;
   localparam logic [OP_W-1:0] OP_JALR   = 5'd22;

endpackage

`default_nettype wire

// ==== src/exu_top.sv ====
`default_nettype none

module exu_top (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        op_valid_i,
   output logic                       op_ready_o,
   input  wire  [exu_pkg::OP_W-1:0]   op_code_i,
   input  wire                        imm_sel_i,
   input  wire  [exu_pkg::XLEN-1:0]   rs1_i,
   input  wire  [exu_pkg::XLEN-1:0]   rs2_i,
   input  wire  [exu_pkg::XLEN-1:0]   imm_i,
   input  wire  [exu_pkg::XLEN-1:0]   pc_i,
   input  wire                        compressed_i,
   output logic                       res_valid_o,
   input  wire                        res_ready_i,
   output logic [exu_pkg::XLEN-1:0]   res_data_o,
   output logic                       jump_valid_o,
   output logic [exu_pkg::XLEN-1:0]   jump_target_o
);
   import exu_pkg::*;

   logic            iss_valid, div_start, alu_take, iss_compressed;
   logic [OP_W-1:0] iss_code;
   logic [XLEN-1:0] iss_a, iss_b, iss_pc, iss_imm;
   logic            div_busy, div_done, div_signed, div_rem;
   logic [XLEN-1:0] div_result;
   logic            alu_jmp_valid;
   logic [XLEN-1:0] alu_result, alu_jmp_target;
   logic            wb_ready;

   assign div_signed = (iss_code == OP_DIV) || (iss_code == OP_REM);
   assign div_rem    = (iss_code == OP_REM) || (iss_code == OP_REMU);

   exu_issue u_issue (
      .clk_i, .rst_i, .op_valid_i, .op_ready_o, .op_code_i, .imm_sel_i,
      .rs1_i, .rs2_i, .imm_i, .pc_i, .compressed_i,
      .wb_ready_i(wb_ready), .div_busy_i(div_busy), .div_done_i(div_done),
      .iss_valid_o(iss_valid), .div_start_o(div_start), .alu_take_o(alu_take),
      .iss_code_o(iss_code), .iss_a_o(iss_a), .iss_b_o(iss_b), .iss_pc_o(iss_pc),
      .iss_imm_o(iss_imm), .iss_compressed_o(iss_compressed));

   exu_alu u_alu (
      .code_i(iss_code), .a_i(iss_a), .b_i(iss_b), .imm_i(iss_imm), .pc_i(iss_pc),
      .compressed_i(iss_compressed), .result_o(alu_result),
      .jmp_valid_o(alu_jmp_valid), .jmp_target_o(alu_jmp_target));

   exu_divider u_div (
      .clk_i, .rst_i, .start_i(div_start), .signed_i(div_signed), .rem_i(div_rem),
      .dividend_i(iss_a), .divisor_i(iss_b),
      .busy_o(div_busy), .done_o(div_done), .result_o(div_result));

   // issue tells which block owns the entry
   exu_writeback u_wb (
      .clk_i, .rst_i,
      .in_valid_i(alu_take ? iss_valid : div_done),
      .in_data_i(alu_take ? alu_result : div_result),
      .in_jmp_valid_i(alu_take && alu_jmp_valid), .in_jmp_target_i(alu_jmp_target),
      .in_ready_o(wb_ready), .res_valid_o, .res_ready_i, .res_data_o,
      .jump_valid_o, .jump_target_o);

endmodule

`default_nettype wire

// ==== src/exu_writeback.sv ====
`default_nettype none

module exu_writeback (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        in_valid_i,
   input  wire  [exu_pkg::XLEN-1:0]   in_data_i,
   input  wire                        in_jmp_valid_i,
   input  wire  [exu_pkg::XLEN-1:0]   in_jmp_target_i,
   output logic                       in_ready_o,
   output logic                       res_valid_o,
   input  wire                        res_ready_i,
   output logic [exu_pkg::XLEN-1:0]   res_data_o,
   output logic                       jump_valid_o,
   output logic [exu_pkg::XLEN-1:0]   jump_target_o
);
   logic full_q;
   logic jv_q;
   logic load;

   assign in_ready_o = !full_q || res_ready_i;   // free, or drained this cycle
   assign load       = in_valid_i && in_ready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         full_q <= 1'b0;
         jv_q   <= 1'b0;
      end else if (load) begin
         full_q <= 1'b1;
         jv_q   <= in_jmp_valid_i;
      end else if (res_ready_i) begin
         full_q <= 1'b0;
         jv_q   <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         res_data_o    <= in_data_i;
         jump_target_o <= in_jmp_target_i;
      end
   end

   assign res_valid_o  = full_q;
   assign jump_valid_o = jv_q;

   a_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
      res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_data_o) &&
                                      $stable(jump_valid_o) && $stable(jump_target_o));

endmodule

`default_nettype wire

// ==== tests/exu_tb.sv ====
`default_nettype none

module exu_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import exu_pkg::*;

   localparam logic [31:0] SEED = 32'hb77920d1;
   localparam int READY_TIMEOUT = 200;
   localparam int RESULT_MARGIN = 48;

   logic            clk_i;
   logic            rst_i;
   logic            op_valid_i;
   logic            op_ready_o;
   logic [OP_W-1:0] op_code_i;
   logic            imm_sel_i;
   logic [XLEN-1:0] rs1_i, rs2_i, imm_i, pc_i;
   logic            compressed_i;
   logic            res_valid_o;
   logic            res_ready_i;
   logic [XLEN-1:0] res_data_o;
   logic            jump_valid_o;
   logic [XLEN-1:0] jump_target_o;

   logic [XLEN-1:0] exp_data[$];
   logic            exp_jv[$];
   logic [XLEN-1:0] exp_jt[$];
   logic [31:0]     op_state = SEED;
   logic [31:0]     bp_state = SEED ^ 32'h5a5a5a5a;   // separate stream for back-pressure
   logic            bp_en;

   exu_top dut_i (
      .clk_i, .rst_i, .op_valid_i, .op_ready_o, .op_code_i, .imm_sel_i,
      .rs1_i, .rs2_i, .imm_i, .pc_i, .compressed_i,
      .res_valid_o, .res_ready_i, .res_data_o, .jump_valid_o, .jump_target_o);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] next_rand();
      op_state = lcg_step(op_state);
      return op_state;
   endfunction

   function automatic logic [31:0] sext12(input logic [31:0] r);
      return {{20{r[11]}}, r[11:0]};
   endfunction

   // RV32IM reference for one operation
   function automatic void model_op(input logic [OP_W-1:0] code, input logic imm_sel,
                                    input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                                    input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
                                    input logic compressed, output logic [XLEN-1:0] res,
                                    output logic jv, output logic [XLEN-1:0] jt);
      logic [XLEN-1:0]        b;
      logic [XLEN-1:0]        link;
      logic [63:0]            prod;
      logic                   ovf;
      logic signed [XLEN-1:0] sa;
      logic signed [XLEN-1:0] sb;
      b    = imm_sel ? imm : rs2;
      sa   = rs1;
      sb   = b;
      link = pc + (compressed ? 32'd2 : 32'd4);
      ovf  = (rs1 == 32'h80000000) && (b == 32'hffffffff);
      res  = '0;
      jv   = 1'b0;
      jt   = '0;
      case (code)
         OP_ADD:    res = rs1 + b;
         OP_SUB:    res = rs1 - b;
         OP_AND:    res = rs1 & b;
         OP_OR:     res = rs1 | b;
         OP_XOR:    res = rs1 ^ b;
         OP_SLL:    res = rs1 << b[4:0];
         OP_SRL:    res = rs1 >> b[4:0];
         OP_SRA:    res = $signed(rs1) >>> b[4:0];
         OP_SLT:    res = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLTU:   res = (rs1 < b) ? 32'd1 : 32'd0;
         OP_MUL: begin
            prod = {32'b0, rs1} * {32'b0, b};
            res  = prod[31:0];
         end
         OP_MULH: begin
            prod = {{32{rs1[31]}}, rs1} * {{32{b[31]}}, b};   // 64-bit wrap gives signed product
            res  = prod[63:32];
         end
         OP_MULHSU: begin
            prod = {{32{rs1[31]}}, rs1} * {32'b0, b};
            res  = prod[63:32];
         end
         OP_MULHU: begin
            prod = {32'b0, rs1} * {32'b0, b};
            res  = prod[63:32];
         end
         OP_DIV: begin
            if (b == 0) begin
               res = '1;
            end else if (ovf) begin
               res = rs1;
            end else begin
               res = sa / sb;
            end
         end
         OP_DIVU:   res = (b == 0) ? '1 : rs1 / b;
         OP_REM: begin
            if (b == 0) begin
               res = rs1;
            end else if (ovf) begin
               res = '0;
            end else begin
               res = sa % sb;
            end
         end
         OP_REMU:   res = (b == 0) ? rs1 : rs1 % b;
         OP_LUI:    res = imm;
         OP_AUIPC:  res = pc + imm;
         OP_MEM:    res = rs1 + imm;
         OP_JAL: begin
            res = link;
            jv  = 1'b1;
            jt  = pc + imm;
         end
         OP_JALR: begin
            res = link;
            jv  = 1'b1;
            jt  = (rs1 + imm) & ~32'h1;
         end
         default:   res = '0;
      endcase
   endfunction

   task automatic stop_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %08h expected %08h", name, got, exp);
         stop_run();
      end
   endtask

   // called on a rising edge, returns on the edge that accepted the operation
   task automatic send_op(input logic [OP_W-1:0] code, input logic imm_sel,
                          input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                          input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
                          input logic compressed);
      logic [XLEN-1:0] res;
      logic [XLEN-1:0] jt;
      logic            jv;
      int              waited;
      op_valid_i   <= 1'b1;
      op_code_i    <= code;
      imm_sel_i    <= imm_sel;
      rs1_i        <= rs1;
      rs2_i        <= rs2;
      imm_i        <= imm;
      pc_i         <= pc;
      compressed_i <= compressed;
      waited = 0;
      @(negedge clk_i);
      while (!op_ready_o) begin
         waited++;
         if (waited > READY_TIMEOUT) begin
            $display("Timeout: op_ready_o stayed low for %0d cycles", READY_TIMEOUT);
            stop_run();
         end
         @(negedge clk_i);
      end
      @(posedge clk_i);
      model_op(code, imm_sel, rs1, rs2, imm, pc, compressed, res, jv, jt);
      exp_data.push_back(res);
      exp_jv.push_back(jv);
      exp_jt.push_back(jt);
   endtask

   task automatic drain_results();
      int idle;
      int left;
      op_valid_i <= 1'b0;
      idle = 0;
      left = exp_data.size();
      while (exp_data.size() != 0) begin
         @(negedge clk_i);
         if (exp_data.size() < left) begin
            left = exp_data.size();
            idle = 0;
         end else begin
            idle++;
         end
         if (idle > DIV_CYCLES + RESULT_MARGIN) begin
            $display("Timeout: no result for %0d cycles, %0d still outstanding", idle, left);
            stop_run();
         end
      end
      @(posedge clk_i);
   endtask

   // a result transfers on the next rising edge when valid and ready at the falling edge
   always @(negedge clk_i) begin
      if (rst_i && res_valid_o && res_ready_i) begin
         if (exp_data.size() == 0) begin
            $display("Unexpected result %08h with no operation outstanding", res_data_o);
            stop_run();
         end else begin
            check_value("res_data_o", res_data_o, exp_data[0]);
            check_value("jump_valid_o", {31'b0, jump_valid_o}, {31'b0, exp_jv[0]});
            if (exp_jv[0]) begin
               check_value("jump_target_o", jump_target_o, exp_jt[0]);
            end
            void'(exp_data.pop_front());
            void'(exp_jv.pop_front());
            void'(exp_jt.pop_front());
         end
      end
   end

   initial begin : ready_driver
      int len;
      forever begin
         @(posedge clk_i);
         if (bp_en) begin
            bp_state = lcg_step(bp_state);
            len = int'(bp_state[27:24] % 12) + 1;
            res_ready_i <= 1'b0;
            repeat (len) @(posedge clk_i);
            res_ready_i <= 1'b1;
            bp_state = lcg_step(bp_state);
            len = int'(bp_state[25:24]);   // ready for len+1 cycles
            repeat (len) @(posedge clk_i);
         end else begin
            res_ready_i <= 1'b1;
         end
      end
   end

   task automatic alu_logic_ops();
      logic [OP_W-1:0] codes [5];
      codes = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
      for (int i = 0; i < 12; i++) begin
         for (int k = 0; k < 5; k++) begin
            send_op(codes[k], i[0], next_rand(), next_rand(), sext12(next_rand()),
                    next_rand(), 1'b0);
         end
      end
      drain_results();
   endtask

   task automatic shift_and_compare();
      logic [OP_W-1:0] codes [5];
      logic [XLEN-1:0] vals [4];
      codes = '{OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
      vals  = '{32'h80000001, 32'hfffffff0, 32'h7ffffff3, 32'hfffffffb};
      for (int k = 0; k < 5; k++) begin
         for (int v = 0; v < 4; v++) begin
            send_op(codes[k], 1'b0, vals[v], 32'd0, 32'd0, 32'd0, 1'b0);
            send_op(codes[k], 1'b1, vals[v], 32'd0, 32'd31, 32'd0, 1'b0);
            send_op(codes[k], 1'b0, vals[v], 32'hffffffe1, 32'd0, 32'd0, 1'b0);
            send_op(codes[k], 1'b0, vals[v], vals[(v + 1) % 4], 32'd0, 32'd0, 1'b0);
         end
         for (int i = 0; i < 6; i++) begin
            send_op(codes[k], i[0], next_rand(), next_rand(), sext12(next_rand()), 32'd0, 1'b0);
         end
      end
      send_op(OP_SLT, 1'b1, 32'hffffffff, 32'd0, 32'd0, 32'd0, 1'b0);   // -1 < 0
      send_op(OP_SLTU, 1'b1, 32'hffffffff, 32'd0, 32'd0, 32'd0, 1'b0);
      drain_results();
   endtask

   task automatic multiply_ops();
      logic [OP_W-1:0] codes [4];
      logic [XLEN-1:0] ext_a [4];
      logic [XLEN-1:0] ext_b [4];
      codes = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
      ext_a = '{32'h80000000, 32'hffffffff, 32'h80000000, 32'h7fffffff};
      ext_b = '{32'h80000000, 32'hffffffff, 32'hffffffff, 32'h80000000};
      for (int k = 0; k < 4; k++) begin
         for (int e = 0; e < 4; e++) begin
            send_op(codes[k], 1'b0, ext_a[e], ext_b[e], 32'd0, 32'd0, 1'b0);
         end
         for (int i = 0; i < 10; i++) begin
            send_op(codes[k], i[0], next_rand(), next_rand(), sext12(next_rand()), 32'd0, 1'b0);
         end
      end
      drain_results();
   endtask

   task automatic divide_ops();
      logic [OP_W-1:0] codes [4];
      logic [XLEN-1:0] r;
      codes = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
      for (int k = 0; k < 4; k++) begin
         for (int i = 0; i < 6; i++) begin
            r = next_rand();
            send_op(codes[k], 1'b0, next_rand(), next_rand() >> r[4:0], 32'd0, 32'd0, 1'b0);
         end
         send_op(codes[k], 1'b0, next_rand(), 32'd0, 32'd0, 32'd0, 1'b0);
         send_op(codes[k], 1'b0, 32'h80000000, 32'hffffffff, 32'd0, 32'd0, 1'b0);
         send_op(codes[k], 1'b1, 32'hffffff9c, 32'd0, 32'hfffffff9, 32'd0, 1'b0);
      end
      drain_results();
   endtask

   task automatic jump_and_upper();
      for (int c = 0; c < 2; c++) begin
         for (int i = 0; i < 4; i++) begin
            send_op(OP_JAL, 1'b1, 32'd0, 32'd0, sext12(next_rand()) & ~32'h1,
                    next_rand() & ~32'h1, c[0]);
            send_op(OP_JALR, 1'b1, next_rand(), 32'd0, sext12(next_rand()),
                    next_rand() & ~32'h1, c[0]);
         end
      end
      for (int i = 0; i < 6; i++) begin
         send_op(OP_LUI, 1'b1, 32'd0, 32'd0, next_rand() & 32'hfffff000, 32'd0, 1'b0);
         send_op(OP_AUIPC, 1'b1, 32'd0, 32'd0, next_rand() & 32'hfffff000, next_rand(), 1'b0);
         send_op(OP_MEM, 1'b1, next_rand(), 32'd0, sext12(next_rand()), 32'd0, 1'b0);
      end
      drain_results();
   endtask

   task automatic stall_stream();
      logic [OP_W-1:0] mix [10];
      logic [XLEN-1:0] r;
      mix = '{OP_ADD, OP_DIV, OP_SUB, OP_REMU, OP_MULH, OP_DIVU, OP_XOR, OP_REM, OP_JAL, OP_SRA};
      bp_en = 1'b1;
      for (int i = 0; i < 60; i++) begin
         r = next_rand();
         send_op(mix[r[31:24] % 10], 1'b0, next_rand(),
                 (r[3:0] == 4'd0) ? 32'd0 : next_rand() >> r[8:4], sext12(next_rand()),
                 next_rand() & ~32'h1, r[12]);
      end
      drain_results();
      bp_en = 1'b0;
   endtask

   initial begin
      rst_i        = 1'b0;
      op_valid_i   = 1'b0;
      op_code_i    = '0;
      imm_sel_i    = 1'b0;
      rs1_i        = '0;
      rs2_i        = '0;
      imm_i        = '0;
      pc_i         = '0;
      compressed_i = 1'b0;
      res_ready_i  = 1'b1;
      bp_en        = 1'b0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      check_value("op_ready_o", {31'b0, op_ready_o}, 32'd1);
      check_value("res_valid_o", {31'b0, res_valid_o}, 32'd0);
      check_value("jump_valid_o", {31'b0, jump_valid_o}, 32'd0);
      @(posedge clk_i);
      alu_logic_ops();
      shift_and_compare();
      multiply_ops();
      divide_ops();
      jump_and_upper();
      stall_stream();
      $display("All tests passed");
      $finish;
   end

endmodule

`default_nettype wire
